// File: Makefile
# Verilator build and run of the memory access unit testbench

VERILATOR ?= verilator
TOP ?= tb_mem_access
OBJ_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILE_LIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mem_access_assert.sv
/*
 * Sequencer assertions
 * Strobe exclusion, one-cycle done and quiet strobes in idle,
 * bound into the access sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module mem_access_assert
(
	input wire logic clk,
	input wire logic i_rst_n,
	input wire mem_pkg::access_state_t i_state,
	input wire logic i_mem_read,
	input wire logic i_mem_write,
	input wire logic i_done
);

	strobe_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_mem_read && i_mem_write))
		else $error("memory read and write strobes high together");

	done_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_done |=> !i_done)
		else $error("done strobe held for more than one cycle");

	idle_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_state == mem_pkg::st_idle) |-> !(i_mem_read || i_mem_write))
		else $error("memory strobe raised while the sequencer is idle");

endmodule : mem_access_assert

bind access_ctrl mem_access_assert u_assert
(
	.clk(clk),
	.i_rst_n(i_rst_n),
	.i_state(state),
	.i_mem_read(o_mem_read),
	.i_mem_write(o_mem_write),
	.i_done(o_done)
);

`default_nettype wire

// File: bench/mem_model.sv
/*
 * Behavioral data memory
 * 256 words with byte-enabled writes and a random number of
 * wait cycles before each response
 */
`timescale 1ns/1ps
`default_nettype none

module mem_model
(
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_read,
	input wire logic i_write,
	input wire mem_pkg::word_t i_addr,
	input wire mem_pkg::word_t i_wdata,
	input wire logic [mem_pkg::BE_W-1:0] i_be,
	output logic o_resp,
	output mem_pkg::word_t o_rdata
);

	localparam int DEPTH = 256;

	mem_pkg::word_t mem [DEPTH];
	logic [1:0] wait_left;
	logic [7:0] idx;

	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] <= {8'(i), ~8'(i)} ^ 16'h3c5a;
	end

	assign idx = i_addr[8:1];
	assign o_rdata = mem[idx];

	// Wait count for the next access is drawn after each response
	assign o_resp = (i_read || i_write) && (wait_left == 2'd0);

	always @(posedge clk)
	begin
		if (!i_rst_n)
			wait_left <= 2'($urandom_range(0, 3));
		else if (o_resp)
		begin
			wait_left <= 2'($urandom_range(0, 3));
			if (i_write && i_be[0])
				mem[idx][7:0] <= i_wdata[7:0];
			if (i_write && i_be[1])
				mem[idx][15:8] <= i_wdata[15:8];
		end
		else if (i_read || i_write)
			wait_left <= wait_left - 2'd1;
	end

endmodule : mem_model

`default_nettype wire

// File: bench/tb_mem_access.sv
/*
 * Testbench for the data memory access unit
 * Runs directed and random loads and stores against a memory
 * model and checks each result against a shadow memory
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access;

	localparam int CLK_PERIOD = 20;
	localparam int DEPTH = 256;
	localparam int N_RANDOM = 40;
	localparam int N_REQ = 19 + N_RANDOM;

	logic clk;
	logic i_rst_n;
	logic req;
	mem_pkg::mem_op_t op;
	mem_pkg::word_t addr;
	mem_pkg::word_t wdata;
	logic mem_resp;
	mem_pkg::word_t mem_rdata;
	logic mem_read;
	logic mem_write;
	mem_pkg::word_t mem_addr;
	mem_pkg::word_t mem_wdata;
	logic [mem_pkg::BE_W-1:0] mem_be;
	mem_pkg::word_t rdata;
	logic done;
	logic busy;

	mem_pkg::word_t shadow [DEPTH];
	mem_pkg::word_t exp_q [$];
	logic is_load_q [$];
	string name_q [$];

	mem_access_unit u_dut
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_req(req),
		.i_op(op),
		.i_addr(addr),
		.i_wdata(wdata),
		.i_mem_resp(mem_resp),
		.i_mem_rdata(mem_rdata),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata),
		.o_mem_be(mem_be),
		.o_rdata(rdata),
		.o_done(done),
		.o_busy(busy)
	);

	mem_model u_mem
	(
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_read(mem_read),
		.i_write(mem_write),
		.i_addr(mem_addr),
		.i_wdata(mem_wdata),
		.i_be(mem_be),
		.o_resp(mem_resp),
		.o_rdata(mem_rdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input mem_pkg::word_t expected,
		input mem_pkg::word_t actual);
		if (expected !== actual)
			fail_run($sformatf("error %s expected %h actual %h", name, expected, actual));
	endtask

	function automatic logic [7:0] word_index(input mem_pkg::word_t a);
		return a[8:1];
	endfunction

	// Expected load value; stores update the shadow and return zero
	function automatic mem_pkg::word_t ref_access(input mem_pkg::mem_op_t o,
		input mem_pkg::word_t a, input mem_pkg::word_t d);
		mem_pkg::word_t w;
		mem_pkg::word_t ptr;
		w = shadow[word_index(a)];
		ptr = w;
		case (o)
			mem_pkg::op_ldw: return w;
			mem_pkg::op_ldb: return a[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
			mem_pkg::op_stw: shadow[word_index(a)] = d;
			mem_pkg::op_stb:
				if (a[0])
					shadow[word_index(a)][15:8] = d[7:0];
				else
					shadow[word_index(a)][7:0] = d[7:0];
			mem_pkg::op_ldi: return shadow[word_index(ptr)];
			default: shadow[word_index(ptr)] = d;
		endcase
		return '0;
	endfunction

	task automatic do_access(input string name, input mem_pkg::mem_op_t o,
		input mem_pkg::word_t a, input mem_pkg::word_t d);
		check_value({name, "_busy_idle"}, 16'd0, busy);
		exp_q.push_back(ref_access(o, a, d));
		is_load_q.push_back(o inside {mem_pkg::op_ldw, mem_pkg::op_ldb, mem_pkg::op_ldi});
		name_q.push_back(name);
		op = o;
		addr = a;
		wdata = d;
		req = 1'b1;
		@(posedge clk);
		#1;
		req = 1'b0;
		check_value({name, "_busy"}, 16'd1, busy);
		while (!done)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	// Compare at every done against the oldest outstanding request
	always @(posedge clk)
	begin
		if (i_rst_n && done)
		begin
			if (exp_q.size() == 0)
				fail_run("o_done appeared without a request");
			else
			begin
				if (is_load_q[0])
					check_value(name_q[0], exp_q[0], rdata);
				void'(exp_q.pop_front());
				void'(is_load_q.pop_front());
				void'(name_q.pop_front());
			end
		end
	end

	initial
	begin
		repeat (N_REQ * 12 + 8) @(posedge clk);
		fail_run("timeout: requests did not complete in time");
	end

	initial
	begin
		mem_pkg::word_t a;
		mem_pkg::word_t t;
		mem_pkg::mem_op_t rop;
		void'($urandom(62));
		clk = 1'b0;
		i_rst_n = 1'b0;
		req = 1'b0;
		op = mem_pkg::op_ldw;
		addr = '0;
		wdata = '0;
		repeat (2) @(posedge clk);
		#1;
		i_rst_n = 1'b1;
		foreach (shadow[i])
			shadow[i] = u_mem.mem[i];

		repeat (4)
		begin
			a = 16'($urandom_range(0, 511)) & 16'hfffe;
			do_access("word_store", mem_pkg::op_stw, a, 16'($urandom));
			do_access("word_load", mem_pkg::op_ldw, a, '0);
		end

		// Byte stores keep the other lane
		a = 16'($urandom_range(0, 511)) & 16'hfffe;
		do_access("byte_base", mem_pkg::op_stw, a, 16'h5aa5);
		do_access("byte_store_odd", mem_pkg::op_stb, a + 16'd1, 16'h00c3);
		do_access("byte_check_odd", mem_pkg::op_ldw, a, '0);
		do_access("byte_store_even", mem_pkg::op_stb, a, 16'h007e);
		do_access("byte_check_even", mem_pkg::op_ldw, a, '0);
		do_access("byte_load_even", mem_pkg::op_ldb, a, '0);
		do_access("byte_load_odd", mem_pkg::op_ldb, a + 16'd1, '0);

		// Pointer word at a, target on another word
		t = a ^ 16'h0100;
		do_access("ptr_setup", mem_pkg::op_stw, a, t);
		do_access("ind_store", mem_pkg::op_sti, a, 16'hbeef);
		do_access("ind_load", mem_pkg::op_ldi, a, '0);
		do_access("ind_target", mem_pkg::op_ldw, t, '0);

		for (int n = 0; n < N_RANDOM; n++)
		begin
			rop = mem_pkg::mem_op_t'(3'($urandom_range(0, 5)));
			do_access($sformatf("random_%0d", n), rop, 16'($urandom_range(0, 511)),
				16'($urandom));
		end

		repeat (4) @(posedge clk);
		if (exp_q.size() != 0)
			fail_run("requests left without o_done");
		else
		begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule : tb_mem_access

`default_nettype wire

// File: list.f
verilog/mem_pkg.sv
verilog/access_ctrl.sv
verilog/request_regs.sv
verilog/store_format.sv
verilog/load_align.sv
verilog/mem_access_unit.sv
bench/mem_model.sv
bench/mem_access_assert.sv
bench/tb_mem_access.sv

// File: verilog/access_ctrl.sv
/*
 * Access sequencer
 * Steps through the optional pointer read and the final data
 * access, holds the memory strobes until each response and
 * signals completion with a one-cycle done
 */
`timescale 1ns/1ps
`default_nettype none

module access_ctrl
(
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_req,
	input wire mem_pkg::mem_op_t i_op,
	input wire logic i_mem_resp,
	output logic o_load_req,
	output logic o_ptr_load,
	output logic o_use_ptr,
	output logic o_result_load,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic o_done,
	output logic o_busy
);

	mem_pkg::access_state_t state;
	mem_pkg::access_state_t state_next;
	logic req_ind;
	logic req_wr;
	logic ind_q;
	logic wr_q;

	// Decode of the incoming request
	always_comb
	begin
		req_ind = (i_op == mem_pkg::op_ldi) || (i_op == mem_pkg::op_sti);
		req_wr = (i_op == mem_pkg::op_stw) || (i_op == mem_pkg::op_stb)
			|| (i_op == mem_pkg::op_sti);
	end

	always_comb
	begin
		state_next = state;
		case (state)
			mem_pkg::st_idle:
				if (i_req)
					state_next = req_ind ? mem_pkg::st_ptr : mem_pkg::st_data;
			mem_pkg::st_ptr:
				if (i_mem_resp)
					state_next = mem_pkg::st_data;
			mem_pkg::st_data:
				if (i_mem_resp)
					state_next = mem_pkg::st_done;
			default:
				state_next = mem_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			state <= mem_pkg::st_idle;
			ind_q <= 1'b0;
			wr_q <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (o_load_req)
			begin
				ind_q <= req_ind;
				wr_q <= req_wr;
			end
		end
	end

	assign o_load_req = i_req && (state == mem_pkg::st_idle);
	assign o_ptr_load = (state == mem_pkg::st_ptr);
	assign o_use_ptr = (state == mem_pkg::st_data) && ind_q;

	// Pointer fetch is always a read, even for an indirect store
	assign o_mem_read = (state == mem_pkg::st_ptr) || ((state == mem_pkg::st_data) && !wr_q);
	assign o_mem_write = (state == mem_pkg::st_data) && wr_q;
	assign o_result_load = (state == mem_pkg::st_data) && !wr_q && i_mem_resp;

	assign o_done = (state == mem_pkg::st_done);
	assign o_busy = (state != mem_pkg::st_idle);

endmodule : access_ctrl

`default_nettype wire

// File: verilog/load_align.sv
/*
 * Load aligner
 * Zero-extends the addressed byte for byte loads, passes the
 * word otherwise and holds the result until the next load
 */
`timescale 1ns/1ps
`default_nettype none

module load_align
(
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_result_load,
	input wire mem_pkg::mem_op_t i_op,
	input wire mem_pkg::word_t i_addr,
	input wire mem_pkg::word_t i_mem_rdata,
	output mem_pkg::word_t o_rdata
);

	localparam int PAD_W = mem_pkg::WORD_W - mem_pkg::BYTE_W;

	mem_pkg::word_t aligned;
	mem_pkg::word_t result_q;

	always_comb
	begin
		if (i_op != mem_pkg::op_ldb)
			aligned = i_mem_rdata;
		else if (i_addr[0])
			aligned = {{PAD_W{1'b0}}, i_mem_rdata[mem_pkg::WORD_W-1:mem_pkg::BYTE_W]};
		else
			aligned = {{PAD_W{1'b0}}, i_mem_rdata[mem_pkg::BYTE_W-1:0]};
	end

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			result_q <= '0;
		else if (i_result_load)
			result_q <= aligned;
	end

	assign o_rdata = result_q;

endmodule : load_align

`default_nettype wire

// File: verilog/mem_access_unit.sv
/*
 * Data memory access unit
 * Carries out word, byte and indirect loads and stores on a
 * word-wide memory port with a response handshake
 */
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit
(
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_req,
	input wire mem_pkg::mem_op_t i_op,
	input wire mem_pkg::word_t i_addr,
	input wire mem_pkg::word_t i_wdata,
	input wire logic i_mem_resp,
	input wire mem_pkg::word_t i_mem_rdata,
	output logic o_mem_read,
	output logic o_mem_write,
	output mem_pkg::word_t o_mem_addr,
	output mem_pkg::word_t o_mem_wdata,
	output logic [mem_pkg::BE_W-1:0] o_mem_be,
	output mem_pkg::word_t o_rdata,
	output logic o_done,
	output logic o_busy
);

	logic load_req;
	logic ptr_load;
	logic use_ptr;
	logic result_load;
	mem_pkg::mem_op_t op_q;
	mem_pkg::word_t wdata_q;

	access_ctrl access_ctrl
	(
		.clk,
		.i_rst_n,
		.i_req,
		.i_op,
		.i_mem_resp,
		.o_load_req(load_req),
		.o_ptr_load(ptr_load),
		.o_use_ptr(use_ptr),
		.o_result_load(result_load),
		.o_mem_read,
		.o_mem_write,
		.o_done,
		.o_busy
	);

	// Selected address drives the port and the lane logic
	request_regs request_regs
	(
		.clk,
		.i_rst_n,
		.i_load_req(load_req),
		.i_op,
		.i_addr,
		.i_wdata,
		.i_ptr_load(ptr_load),
		.i_use_ptr(use_ptr),
		.i_mem_resp,
		.i_mem_rdata,
		.o_op(op_q),
		.o_addr(o_mem_addr),
		.o_wdata(wdata_q)
	);

	store_format store_format
	(
		.i_op(op_q),
		.i_addr(o_mem_addr),
		.i_wdata(wdata_q),
		.o_mem_wdata,
		.o_mem_be
	);

	load_align load_align
	(
		.clk,
		.i_rst_n,
		.i_result_load(result_load),
		.i_op(op_q),
		.i_addr(o_mem_addr),
		.i_mem_rdata,
		.o_rdata
	);

endmodule : mem_access_unit

`default_nettype wire

// File: verilog/mem_pkg.sv
/*
 * Data memory access unit package
 * Widths, the word type, the request operations and the
 * states of the access sequencer
 */
`default_nettype none

package mem_pkg;

	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;
	localparam int BE_W = 2;

	typedef logic [WORD_W-1:0] word_t;

	typedef enum logic [2:0] {
		op_ldw,
		op_ldb,
		op_stw,
		op_stb,
		op_ldi,
		op_sti
	} mem_op_t;

	// Pointer read only happens for indirect ops
	typedef enum logic [1:0] {
		st_idle,
		st_ptr,
		st_data,
		st_done
	} access_state_t;

endpackage : mem_pkg

`default_nettype wire

// File: verilog/request_regs.sv
/*
 * Request registers
 * Latch the operation, address and store data of a request,
 * capture the pointer word of an indirect access and select
 * the address of the current access
 */
`timescale 1ns/1ps
`default_nettype none

module request_regs
(
	input wire logic clk,
	input wire logic i_rst_n,
	input wire logic i_load_req,
	input wire mem_pkg::mem_op_t i_op,
	input wire mem_pkg::word_t i_addr,
	input wire mem_pkg::word_t i_wdata,
	input wire logic i_ptr_load,
	input wire logic i_use_ptr,
	input wire logic i_mem_resp,
	input wire mem_pkg::word_t i_mem_rdata,
	output mem_pkg::mem_op_t o_op,
	output mem_pkg::word_t o_addr,
	output mem_pkg::word_t o_wdata
);

	mem_pkg::mem_op_t op_q;
	mem_pkg::word_t addr_q;
	mem_pkg::word_t wdata_q;
	mem_pkg::word_t ptr_q;

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			op_q <= mem_pkg::op_ldw;
		else if (i_load_req)
			op_q <= i_op;
	end

	always_ff @(posedge clk)
	begin
		if (i_load_req)
		begin
			addr_q <= i_addr;
			wdata_q <= i_wdata;
		end
		// Pointer arrives with the first read response
		if (i_ptr_load && i_mem_resp)
			ptr_q <= i_mem_rdata;
	end

	assign o_op = op_q;
	assign o_wdata = wdata_q;
	assign o_addr = i_use_ptr ? ptr_q : addr_q;

endmodule : request_regs

`default_nettype wire

// File: verilog/store_format.sv
/*
 * Store formatter
 * Builds the memory write word and byte enables; a byte store
 * is copied into both lanes with one enable set
 */
`timescale 1ns/1ps
`default_nettype none

module store_format
(
	input wire mem_pkg::mem_op_t i_op,
	input wire mem_pkg::word_t i_addr,
	input wire mem_pkg::word_t i_wdata,
	output mem_pkg::word_t o_mem_wdata,
	output logic [mem_pkg::BE_W-1:0] o_mem_be
);

	logic [mem_pkg::BYTE_W-1:0] low_byte;

	assign low_byte = i_wdata[mem_pkg::BYTE_W-1:0];

	always_comb
	begin
		if (i_op == mem_pkg::op_stb)
		begin
			o_mem_wdata = {low_byte, low_byte};
			// Odd address selects the high lane
			if (i_addr[0])
				o_mem_be = 2'b10;
			else
				o_mem_be = 2'b01;
		end
		else
		begin
			o_mem_wdata = i_wdata;
			o_mem_be = 2'b11;
		end
	end

endmodule : store_format

`default_nettype wire
